// ==== echo_ctrl.sv ====
`timescale 1ns/1ps

module echo_ctrl (
    input  logic                 clk,         // system clock
    input  logic                 rst_i,       // sync reset, active high
    input  logic                 rx_evt_i,    // byte received
    input  uart_echo_pkg::byte_t rx_data_i,
    input  logic                 tx_busy_i,   // transmitter in a frame
    output logic                 tx_start_o,  // one-cycle send strobe
    output uart_echo_pkg::byte_t tx_data_o
);
    import uart_echo_pkg::*;

    ctrl_state_e state;
    byte_t       hold_q;     // one-byte holding register
    logic        pending;    // hold_q not yet sent
    logic        busy_seen;  // transmitter has taken the byte

    assign tx_start_o = (state == CTRL_SEND);
    assign tx_data_o  = hold_q;

    // newest byte wins, older unsent byte is lost
    always_ff @(posedge clk) begin
        if (rx_evt_i) hold_q <= rx_data_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state     <= CTRL_IDLE;
            pending   <= 1'b0;
            busy_seen <= 1'b0;
        end else begin
            if (rx_evt_i) pending <= 1'b1;

            case (state)
                CTRL_IDLE: begin
                    if ((rx_evt_i || pending) && !tx_busy_i) state <= CTRL_SEND;
                end
                CTRL_SEND: begin
                    if (!rx_evt_i) pending <= 1'b0;  // byte handed over
                    busy_seen <= 1'b0;
                    state     <= CTRL_WAIT_BUSY;
                end
                CTRL_WAIT_BUSY: begin
                    if (tx_busy_i) begin
                        busy_seen <= 1'b1;
                    end else if (busy_seen) begin  // frame done
                        busy_seen <= 1'b0;
                        state     <= (pending || rx_evt_i) ? CTRL_SEND : CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

// ==== irq_timer.sv ====
`timescale 1ns/1ps

module irq_timer (
    input  logic clk,    // system clock
    input  logic rst_i,  // sync reset, active high
    output logic irq_o   // periodic interrupt pulse
);
    import uart_echo_pkg::*;

    logic [TIMER_CNT_W-1:0] period_cnt;
    logic                   armed;  // set after the first full period
    logic                   wrap;

    assign wrap = (period_cnt == TIMER_CNT_W'(TIMER_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            period_cnt <= '0;
            armed      <= 1'b0;
            irq_o      <= 1'b0;
        end else begin
            period_cnt <= wrap ? '0 : period_cnt + 1'b1;
            if (wrap) armed <= 1'b1;
            // no pulse during the first period after reset
            irq_o <= armed && (period_cnt < TIMER_CNT_W'(IRQ_WIDTH));
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART echo testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing -f sim.f --top-module tb_uart_echo \
    -Mdir obj_dir -o sim_uart_echo
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_uart_echo
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0

// ==== sim.f ====
uart_echo_pkg.sv
uart_rx.sv
uart_tx.sv
irq_timer.sv
echo_ctrl.sv
uart_echo_top.sv
tb_clk_gen.sv
tb_uart_echo.sv

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,  // 4 ns period
    output logic rst_o   // high for the first 3 cycles
);
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;  // released on a falling edge
    end

endmodule

// ==== tb_uart_echo.sv ====
`timescale 1ns/1ps

module tb_uart_echo;
    import uart_echo_pkg::*;

    localparam int     CLK_NS       = 4;
    localparam int     STREAM_BYTES = 40;
    localparam int     ERR_FRAMES   = 20;
    localparam int     NUM_FRAMES   = 1 + STREAM_BYTES + ERR_FRAMES;
    localparam int     SETTLE_CYC   = 2 * 10 * CLKS_PER_BIT;  // two frame times
    localparam longint WATCHDOG_NS  = longint'(NUM_FRAMES) * 10 * CLKS_PER_BIT * CLK_NS * 3
                                      + longint'(4 * TIMER_PERIOD * CLK_NS);

    logic  clk;
    logic  rst_i;
    logic  uart_rx_i;
    logic  uart_tx_o;
    logic  irq_o;
    int    cyc = 0;              // posedges since reset release
    logic  reset_seen = 1'b0;
    int    irq_rises = 0;
    logic  irq_prev = 1'b0;
    byte_t model_q[$];           // good bytes sent, in order
    byte_t got_q[$];             // bytes decoded from uart_tx_o

    tb_clk_gen u_clk_gen (
        .clk_o ( clk   ),
        .rst_o ( rst_i )
    );

    uart_echo_top u_dut (
        .clk       ( clk       ),
        .rst_i     ( rst_i     ),
        .uart_rx_i ( uart_rx_i ),
        .uart_tx_o ( uart_tx_o ),
        .irq_o     ( irq_o     )
    );

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("Error at %0t: %s expected %0h, actual %0h", $time, name, exp_v, act_v);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // called on a falling edge, returns on one
    task automatic send_frame(input byte_t data, input logic stop_val);
        logic [9:0] frame;
        frame = {stop_val, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            uart_rx_i = frame[b];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        uart_rx_i = 1'b1;
    endtask

    task automatic send_stream(input int count, input bit with_errors);
        byte_t data;
        logic  bad;
        int    gap;
        for (int i = 0; i < count; i++) begin
            data = byte_t'($urandom);
            bad  = with_errors && (i == 2 || ($urandom % 4) == 0);
            gap  = int'($urandom % 4);  // idle bit times
            if (bad && gap == 0) gap = 1;  // next start edge needs a high line first
            send_frame(data, ~bad);
            if (!bad) model_q.push_back(data);
            repeat (gap * CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic check_echoes();
        while (got_q.size() < model_q.size()) @(negedge clk);
        repeat (SETTLE_CYC) @(negedge clk);  // room for a stray frame
        check_value("echo count", 32'(model_q.size()), 32'(got_q.size()));
        for (int i = 0; i < model_q.size(); i++) begin
            check_value("echoed byte", 32'(model_q[i]), 32'(got_q[i]));
        end
        model_q.delete();
        got_q.delete();
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            cyc        <= 0;
            reset_seen <= 1'b1;
        end else if (reset_seen) begin
            cyc <= cyc + 1;
        end
    end

    // pulse rises TIMER_PERIOD cycles after the first edge out of reset
    always @(negedge clk) begin
        logic exp_irq;
        if (reset_seen) begin
            exp_irq = (cyc > TIMER_PERIOD) && (((cyc - 1) % TIMER_PERIOD) < IRQ_WIDTH);
            check_value("irq_o", 32'(exp_irq), 32'(irq_o));
            if (irq_o && !irq_prev) irq_rises = irq_rises + 1;
            irq_prev = irq_o;
        end
    end

    // decodes echoed frames, every sample of a bit must match
    initial begin : tx_monitor
        logic  prev_tx;
        logic  bit_val;
        byte_t data;
        prev_tx = 1'b1;
        forever begin
            @(negedge clk);
            if (cyc > 0 && prev_tx === 1'b1 && uart_tx_o === 1'b0) begin
                for (int s = 1; s < CLKS_PER_BIT; s++) begin
                    @(negedge clk);
                    check_value("uart_tx_o start bit", 32'd0, 32'(uart_tx_o));
                end
                for (int b = 0; b < DATA_BITS; b++) begin
                    for (int s = 0; s < CLKS_PER_BIT; s++) begin
                        @(negedge clk);
                        if (s == 0) bit_val = uart_tx_o;
                        else check_value("uart_tx_o data bit", 32'(bit_val), 32'(uart_tx_o));
                        if (s == CLKS_PER_BIT / 2) data[b] = uart_tx_o;  // mid-bit
                    end
                end
                for (int s = 0; s < CLKS_PER_BIT; s++) begin
                    @(negedge clk);
                    check_value("uart_tx_o stop bit", 32'd1, 32'(uart_tx_o));
                end
                got_q.push_back(data);
            end
            prev_tx = uart_tx_o;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all echoes were checked");
        $display("** FAIL **");
        $fatal(1, "simulation timeout");
    end

    initial begin
        uart_rx_i = 1'b1;  // idle line
        void'($urandom(97));
        while (cyc == 0) @(negedge clk);
        repeat (20) begin  // quiet outputs before any frame
            check_value("uart_tx_o", 32'd1, 32'(uart_tx_o));
            check_value("irq_o", 32'd0, 32'(irq_o));
            @(negedge clk);
        end
        send_stream(1, 1'b0);  // single echo
        check_echoes();
        send_stream(STREAM_BYTES, 1'b0);
        check_echoes();
        send_stream(ERR_FRAMES, 1'b1);  // bad stop bits mixed in
        check_echoes();
        if (irq_rises < 3) begin
            $display("irq_o pulsed only %0d times, at least 3 periods expected", irq_rises);
            $display("** FAIL **");
            $fatal(1, "too few interrupt pulses");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== uart_echo_pkg.sv ====
package uart_echo_pkg;

    // serial timing, scaled down for simulation
    localparam int CLKS_PER_BIT = 16;                     // clock cycles per serial bit
    localparam int DATA_BITS    = 8;                      // 8N1 frame
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);   // bit-time counter width
    localparam int BIT_IDX_W    = $clog2(DATA_BITS);      // data bit index width

    // interrupt pulse timing
    localparam int TIMER_PERIOD = 600;                    // cycles between pulse starts
    localparam int IRQ_WIDTH    = 2;                      // pulse high time in cycles
    localparam int TIMER_CNT_W  = $clog2(TIMER_PERIOD);

    typedef logic [DATA_BITS-1:0] byte_t;

    // shared by receiver and transmitter
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    // echo control FSM
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_SEND,
        CTRL_WAIT_BUSY
    } ctrl_state_e;

endpackage

// ==== uart_echo_top.sv ====
`timescale 1ns/1ps

module uart_echo_top (
    input  logic clk,        // system clock
    input  logic rst_i,      // sync reset, active high
    input  logic uart_rx_i,  // serial in
    output logic uart_tx_o,  // echoed serial out
    output logic irq_o       // periodic interrupt
);
    import uart_echo_pkg::*;

    logic  rx_evt;
    byte_t rx_data;
    logic  tx_start;
    byte_t tx_data;
    logic  tx_busy;

    uart_rx u_uart_rx (
        .clk        ( clk       ),
        .rst_i      ( rst_i     ),
        .rx_i       ( uart_rx_i ),
        .rx_evt_o   ( rx_evt    ),
        .rx_data_o  ( rx_data   )
    );

    echo_ctrl u_echo_ctrl (
        .clk        ( clk       ),
        .rst_i      ( rst_i     ),
        .rx_evt_i   ( rx_evt    ),
        .rx_data_i  ( rx_data   ),
        .tx_busy_i  ( tx_busy   ),
        .tx_start_o ( tx_start  ),
        .tx_data_o  ( tx_data   )
    );

    uart_tx u_uart_tx (
        .clk        ( clk       ),
        .rst_i      ( rst_i     ),
        .tx_start_i ( tx_start  ),
        .tx_data_i  ( tx_data   ),
        .tx_busy_o  ( tx_busy   ),
        .tx_o       ( uart_tx_o )
    );

    irq_timer u_irq_timer (
        .clk        ( clk       ),
        .rst_i      ( rst_i     ),
        .irq_o      ( irq_o     )  // straight to the pin
    );

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,         // system clock
    input  logic                 rst_i,       // sync reset, active high
    input  logic                 rx_i,        // serial line in
    output logic                 rx_evt_o,    // one-cycle strobe, good byte
    output uart_echo_pkg::byte_t rx_data_o    // valid with rx_evt_o
);
    import uart_echo_pkg::*;

    logic                 rx_meta;    // first sync stage
    logic                 rx_sync;    // second sync stage
    logic                 rx_sync_q;  // for edge detect
    logic                 start_edge;
    logic                 half_end;
    logic                 bit_end;
    uart_state_e          state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    byte_t                shift_q;

    assign start_edge = rx_sync_q & ~rx_sync;
    assign half_end   = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end    = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign rx_data_o  = shift_q;  // stable through the stop bit

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rx_meta   <= 1'b1;  // line idles high
            rx_sync   <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta   <= rx_i;
            rx_sync   <= rx_meta;
            rx_sync_q <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= UART_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_evt_o <= 1'b0;
        end else begin
            rx_evt_o <= 1'b0;
            case (state)
                UART_IDLE: begin
                    bit_cnt <= '0;
                    if (start_edge) state <= UART_START;
                end
                UART_START: begin  // wait half a bit, recheck start
                    if (half_end) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? UART_IDLE : UART_DATA;  // glitch, drop it
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) state <= UART_STOP;
                        else bit_idx <= bit_idx + 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        bit_cnt  <= '0;
                        rx_evt_o <= rx_sync;  // low stop bit, frame dropped
                        state    <= UART_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == UART_DATA && bit_end) shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,         // system clock
    input  logic                 rst_i,       // sync reset, active high
    input  logic                 tx_start_i,  // one-cycle start strobe
    input  uart_echo_pkg::byte_t tx_data_i,   // byte to send
    output logic                 tx_busy_o,   // high until end of stop bit
    output logic                 tx_o         // serial line out
);
    import uart_echo_pkg::*;

    uart_state_e          state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    logic                 bit_end;
    logic                 load;
    byte_t                shift_q;

    assign bit_end = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign load    = (state == UART_IDLE) && tx_start_i;  // strobes ignored while busy

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state     <= UART_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            tx_busy_o <= 1'b0;
            tx_o      <= 1'b1;  // idle line
        end else begin
            if (state == UART_IDLE || bit_end) bit_cnt <= '0;
            else bit_cnt <= bit_cnt + 1'b1;

            case (state)
                UART_IDLE: begin
                    if (load) begin
                        state     <= UART_START;
                        tx_busy_o <= 1'b1;
                        tx_o      <= 1'b0;  // start bit
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state   <= UART_DATA;
                        bit_idx <= '0;
                        tx_o    <= shift_q[0];
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
                            state <= UART_STOP;
                            tx_o  <= 1'b1;  // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_o    <= shift_q[0];
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state     <= UART_IDLE;
                        tx_busy_o <= 1'b0;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // next data bit always sits in bit 0
    always_ff @(posedge clk) begin
        if (load) shift_q <= tx_data_i;
        else if (bit_end && (state == UART_START || state == UART_DATA)) shift_q <= shift_q >> 1;
    end

endmodule
